//--- src/fv_cfg_pkg.sv
`default_nettype none

package fv_cfg_pkg;

    localparam int node_id_w   = 8;
    localparam int num_edge_pe = 4;
    localparam int pe_tag_w    = $clog2(num_edge_pe);
    localparam int fv_line_w   = 8;                        // Feature-vector line.
    localparam int fv_off_w    = 4;                        // Offset within line.
    localparam int fv_addr_w   = fv_line_w + fv_off_w;
    localparam int num_banks   = 2;
    localparam int bank_depth  = 128;
    localparam int bank_addr_w = $clog2(bank_depth);
    localparam int req_depth   = 8;
    localparam int res_depth   = 4;

endpackage

`default_nettype wire

//--- src/fv_info_pkg.sv
`default_nettype none

package fv_info_pkg;

    // Lookup request from a processing element.
    typedef struct packed {
        logic [fv_cfg_pkg::node_id_w-1:0] node_id;
        logic [fv_cfg_pkg::pe_tag_w-1:0]  pe_tag;
    } fv_req_t;

    // Lookup result returned to the tagged PE.
    typedef struct packed {
        logic [fv_cfg_pkg::fv_addr_w-1:0] fv_addr;
        logic [fv_cfg_pkg::pe_tag_w-1:0]  pe_tag;
    } fv_result_t;

endpackage

`default_nettype wire

//--- src/fv_result_if.sv
`default_nettype none

interface fv_result_if;

    logic                             valid;    // One-cycle result pulse.
    logic [fv_cfg_pkg::fv_addr_w-1:0] fv_addr;
    logic [fv_cfg_pkg::pe_tag_w-1:0]  pe_tag;
    logic                             full;     // Merger queue near capacity.

    modport cntl (
        output valid, fv_addr, pe_tag,
        input  full
    );

    modport merge (
        input  valid, fv_addr, pe_tag,
        output full
    );

endinterface

`default_nettype wire

//--- src/req_fifo.sv
`default_nettype none

module req_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     wr,
    input  payload_t wdata,
    input  logic     rd,
    output payload_t rdata,
    output logic     empty,
    output logic     full,
    output logic     almost_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr && !full;                            // Overflow dropped.
    assign do_rd = rd && !empty;

    assign empty       = (count == '0);
    assign full        = (count == cnt_w'(depth));
    assign almost_full = (count >= cnt_w'(depth - 1));
    assign rdata       = mem[rd_ptr];                      // Head of queue.

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/fv_info_sram.sv
`default_nettype none

module fv_info_sram (
    input  logic                               clk,
    input  logic                               we,
    input  logic [fv_cfg_pkg::bank_addr_w-1:0] waddr,
    input  logic [fv_cfg_pkg::fv_addr_w-1:0]   wdata,
    input  logic                               cen,
    input  logic [fv_cfg_pkg::bank_addr_w-1:0] raddr,
    output logic [fv_cfg_pkg::fv_addr_w-1:0]   rdata
);

    logic [fv_cfg_pkg::fv_addr_w-1:0] mem [fv_cfg_pkg::bank_depth];

    // Table load port.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            rdata <= mem[raddr];                           // Held when idle.
        end
    end

endmodule

`default_nettype wire

//--- src/fv_info_mem_cntl.sv
`default_nettype none

module fv_info_mem_cntl (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               empty,
    input  fv_info_pkg::fv_req_t               head,
    output logic                               pop,
    output logic                               sram_cen,
    output logic [fv_cfg_pkg::bank_addr_w-1:0] sram_addr,
    input  logic [fv_cfg_pkg::fv_addr_w-1:0]   sram_rdata,
    fv_result_if.cntl                          res
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        FETCH
    } state_t;

    state_t                             state, nx_state;
    logic                               nx_pop, nx_cen;
    logic [fv_cfg_pkg::bank_addr_w-1:0] nx_addr;
    logic [fv_cfg_pkg::pe_tag_w-1:0]    tag_q, nx_tag;
    logic                               rd_done, nx_rd_done;
    logic                               valid_q, nx_valid;
    logic [fv_cfg_pkg::fv_addr_w-1:0]   fv_addr_q, nx_fv_addr;
    logic [fv_cfg_pkg::pe_tag_w-1:0]    res_tag_q, nx_res_tag;

    assign res.valid   = valid_q;
    assign res.fv_addr = fv_addr_q;
    assign res.pe_tag  = res_tag_q;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= IDLE;
            pop       <= 1'b0;
            sram_cen  <= 1'b0;
            sram_addr <= '0;
            tag_q     <= '0;
            rd_done   <= 1'b0;
            valid_q   <= 1'b0;
            fv_addr_q <= '0;
            res_tag_q <= '0;
        end else begin
            state     <= nx_state;
            pop       <= nx_pop;
            sram_cen  <= nx_cen;
            sram_addr <= nx_addr;
            tag_q     <= nx_tag;
            rd_done   <= nx_rd_done;
            valid_q   <= nx_valid;
            fv_addr_q <= nx_fv_addr;
            res_tag_q <= nx_res_tag;
        end
    end

    always_comb begin
        nx_state   = state;
        nx_pop     = 1'b0;
        nx_cen     = 1'b0;
        nx_addr    = sram_addr;
        nx_tag     = tag_q;
        nx_rd_done = 1'b0;
        nx_valid   = 1'b0;
        nx_fv_addr = fv_addr_q;
        nx_res_tag = res_tag_q;
        if (rd_done) begin                                 // SRAM data is ready.
            nx_valid   = 1'b1;
            nx_fv_addr = sram_rdata;
            nx_res_tag = tag_q;
        end
        case (state)
            IDLE: begin
                if (!empty && !res.full) begin
                    nx_pop   = 1'b1;
                    nx_state = ADDR;
                end
            end
            ADDR: begin
                nx_cen   = 1'b1;
                nx_addr  = head.node_id[fv_cfg_pkg::node_id_w-1:1];  // Drop bank bit.
                nx_tag   = head.pe_tag;
                nx_state = FETCH;
            end
            FETCH: begin
                nx_rd_done = 1'b1;
                nx_state   = IDLE;
            end
            default: nx_state = IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- src/fv_info_lane.sv
`default_nettype none

module fv_info_lane #(
    parameter bit lane_id = 1'b0
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             in_wr,
    input  logic [fv_cfg_pkg::node_id_w-1:0] in_node_id,
    input  logic [fv_cfg_pkg::pe_tag_w-1:0]  in_pe_tag,
    output logic                             in_full,
    input  logic                             load_en,
    input  logic [fv_cfg_pkg::node_id_w-1:0] load_addr,
    input  logic [fv_cfg_pkg::fv_addr_w-1:0] load_data,
    fv_result_if.cntl                        res
);

    fv_info_pkg::fv_req_t               req;
    fv_info_pkg::fv_req_t               head;
    logic                               req_wr;
    logic                               q_empty;
    logic                               q_pop;
    logic                               load_we;
    logic                               sram_cen;
    logic [fv_cfg_pkg::bank_addr_w-1:0] sram_addr;
    logic [fv_cfg_pkg::fv_addr_w-1:0]   sram_rdata;

    assign req_wr      = in_wr && (in_node_id[0] == lane_id);   // Our bank only.
    assign req.node_id = in_node_id;
    assign req.pe_tag  = in_pe_tag;
    assign load_we     = load_en && (load_addr[0] == lane_id);

    req_fifo #(
        .payload_t (fv_info_pkg::fv_req_t),
        .depth     (fv_cfg_pkg::req_depth)
    ) i_req_fifo (
        .clk         (clk),
        .reset       (reset),
        .wr          (req_wr),
        .wdata       (req),
        .rd          (q_pop),
        .rdata       (head),
        .empty       (q_empty),
        .full        (in_full),
        .almost_full ()
    );

    fv_info_mem_cntl i_cntl (
        .clk        (clk),
        .reset      (reset),
        .empty      (q_empty),
        .head       (head),
        .pop        (q_pop),
        .sram_cen   (sram_cen),
        .sram_addr  (sram_addr),
        .sram_rdata (sram_rdata),
        .res        (res)
    );

    fv_info_sram i_sram (
        .clk   (clk),
        .we    (load_we),
        .waddr (load_addr[fv_cfg_pkg::node_id_w-1:1]),
        .wdata (load_data),
        .cen   (sram_cen),
        .raddr (sram_addr),
        .rdata (sram_rdata)
    );

endmodule

`default_nettype wire

//--- src/fv_result_merge.sv
`default_nettype none

module fv_result_merge (
    input  logic                             clk,
    input  logic                             reset,
    fv_result_if.merge                       lane0,
    fv_result_if.merge                       lane1,
    input  logic                             out_full,
    output logic                             out_valid,
    output logic [fv_cfg_pkg::fv_addr_w-1:0] out_fv_addr,
    output logic [fv_cfg_pkg::pe_tag_w-1:0]  out_pe_tag,
    output logic                             out_bank
);

    fv_info_pkg::fv_result_t wdata0, wdata1;
    fv_info_pkg::fv_result_t head0, head1;
    logic                    empty0, empty1;
    logic                    issue;
    logic                    sel;                          // Lane being issued.
    logic                    prio;                         // Preferred lane.

    assign wdata0 = '{fv_addr: lane0.fv_addr, pe_tag: lane0.pe_tag};
    assign wdata1 = '{fv_addr: lane1.fv_addr, pe_tag: lane1.pe_tag};

    req_fifo #(
        .payload_t (fv_info_pkg::fv_result_t),
        .depth     (fv_cfg_pkg::res_depth)
    ) i_res_fifo0 (
        .clk (clk), .reset (reset),
        .wr (lane0.valid), .wdata (wdata0),
        .rd (issue && !sel), .rdata (head0),
        .empty (empty0), .full (), .almost_full (lane0.full)
    );

    req_fifo #(
        .payload_t (fv_info_pkg::fv_result_t),
        .depth     (fv_cfg_pkg::res_depth)
    ) i_res_fifo1 (
        .clk (clk), .reset (reset),
        .wr (lane1.valid), .wdata (wdata1),
        .rd (issue && sel), .rdata (head1),
        .empty (empty1), .full (), .almost_full (lane1.full)
    );

    assign issue = !out_full && !(empty0 && empty1);
    assign sel   = (!empty0 && !empty1) ? prio : empty0;  // Round robin when both.

    always_ff @(posedge clk) begin
        if (!reset) begin
            out_valid <= 1'b0;
            prio      <= 1'b0;
        end else begin
            out_valid <= issue;
            if (issue) begin
                prio <= ~sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            out_fv_addr <= sel ? head1.fv_addr : head0.fv_addr;
            out_pe_tag  <= sel ? head1.pe_tag : head0.pe_tag;
            out_bank    <= sel;
        end
    end

endmodule

`default_nettype wire

//--- src/fv_info_lookup_top.sv
`default_nettype none

module fv_info_lookup_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             in_wr,
    input  logic [fv_cfg_pkg::node_id_w-1:0] in_node_id,
    input  logic [fv_cfg_pkg::pe_tag_w-1:0]  in_pe_tag,
    output logic [fv_cfg_pkg::num_banks-1:0] in_full,
    input  logic                             load_en,
    input  logic [fv_cfg_pkg::node_id_w-1:0] load_addr,
    input  logic [fv_cfg_pkg::fv_addr_w-1:0] load_data,
    input  logic                             out_full,
    output logic                             out_valid,
    output logic [fv_cfg_pkg::fv_addr_w-1:0] out_fv_addr,
    output logic [fv_cfg_pkg::pe_tag_w-1:0]  out_pe_tag,
    output logic                             out_bank
);

    fv_result_if lane0_res ();
    fv_result_if lane1_res ();

    fv_info_lane #(.lane_id (1'b0)) i_lane0 (
        .clk (clk), .reset (reset),
        .in_wr (in_wr), .in_node_id (in_node_id), .in_pe_tag (in_pe_tag),
        .in_full (in_full[0]),
        .load_en (load_en), .load_addr (load_addr), .load_data (load_data),
        .res (lane0_res.cntl)
    );

    fv_info_lane #(.lane_id (1'b1)) i_lane1 (
        .clk (clk), .reset (reset),
        .in_wr (in_wr), .in_node_id (in_node_id), .in_pe_tag (in_pe_tag),
        .in_full (in_full[1]),
        .load_en (load_en), .load_addr (load_addr), .load_data (load_data),
        .res (lane1_res.cntl)
    );

    fv_result_merge i_merge (
        .clk (clk), .reset (reset),
        .lane0 (lane0_res.merge), .lane1 (lane1_res.merge),
        .out_full (out_full), .out_valid (out_valid),
        .out_fv_addr (out_fv_addr), .out_pe_tag (out_pe_tag), .out_bank (out_bank)
    );

endmodule

`default_nettype wire

//--- verification/fv_lookup_assertions.sv
`default_nettype none

module fv_lookup_assertions (
    input logic                             clk,
    input logic                             reset,
    input logic                             out_full,
    input logic                             out_valid,
    input logic [fv_cfg_pkg::num_banks-1:0] in_full
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_fails = 0;

    // Merger must hold off after a full cycle.
    hold_off: assert property (@(posedge clk) disable iff (!reset)
        out_full |=> !out_valid)
        else begin
            assert_fails++;
            $error("out_valid rose in the cycle after out_full was high");
        end

    quiet_in_reset: assert property (@(posedge clk) !reset |=> !out_valid)
        else begin
            assert_fails++;
            $error("out_valid was high during reset");
        end

    full_known: assert property (@(posedge clk) disable iff (!reset)
        !$isunknown(in_full))
        else begin
            assert_fails++;
            $error("in_full has an unknown bit after reset");
        end

endmodule

`default_nettype wire

//--- verification/tb_fv_info_lookup.sv
`default_nettype none

module tb_fv_info_lookup;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int seed = 15878;

    typedef struct packed {
        logic [fv_cfg_pkg::node_id_w-1:0] node_id;
        logic [fv_cfg_pkg::fv_addr_w-1:0] fv_addr;
        logic [fv_cfg_pkg::pe_tag_w-1:0]  pe_tag;
    } exp_t;

    logic                             clk = 1'b0;
    logic                             reset;
    logic                             in_wr;
    logic [fv_cfg_pkg::node_id_w-1:0] in_node_id;
    logic [fv_cfg_pkg::pe_tag_w-1:0]  in_pe_tag;
    logic [fv_cfg_pkg::num_banks-1:0] in_full;
    logic                             load_en;
    logic [fv_cfg_pkg::node_id_w-1:0] load_addr;
    logic [fv_cfg_pkg::fv_addr_w-1:0] load_data;
    logic                             out_full;
    logic                             out_valid;
    logic [fv_cfg_pkg::fv_addr_w-1:0] out_fv_addr;
    logic [fv_cfg_pkg::pe_tag_w-1:0]  out_pe_tag;
    logic                             out_bank;

    logic [fv_cfg_pkg::fv_addr_w-1:0] table_model [2**fv_cfg_pkg::node_id_w];
    exp_t exp_q0 [$];                                      // Bank 0 in request order.
    exp_t exp_q1 [$];
    byte  cmd_op [$];
    int   cmd_a  [$];
    int   cmd_b  [$];
    int   n_cmds     = 0;
    int   err_count  = 0;
    int   n_requests = 0;
    int   n_results  = 0;
    int   stall_left = 0;

    always #4 clk = ~clk;

    fv_info_lookup_top i_dut (
        .clk (clk), .reset (reset),
        .in_wr (in_wr), .in_node_id (in_node_id), .in_pe_tag (in_pe_tag),
        .in_full (in_full),
        .load_en (load_en), .load_addr (load_addr), .load_data (load_data),
        .out_full (out_full), .out_valid (out_valid),
        .out_fv_addr (out_fv_addr), .out_pe_tag (out_pe_tag), .out_bank (out_bank)
    );

    bind fv_info_lookup_top fv_lookup_assertions i_assertions (
        .clk (clk), .reset (reset), .out_full (out_full),
        .out_valid (out_valid), .in_full (in_full)
    );

    task automatic read_commands();
        int    fd;
        string line;
        string op;
        int    a;
        int    b;
        fd = $fopen("verification/fv_lookup_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the command file verification/fv_lookup_input.txt");
            $display("Test failures found");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    b = 0;
                    void'($sscanf(line, "%s %h %h", op, a, b));
                    assert (op == "L" || op == "R" || op == "S" || op == "W") else begin
                        err_count++;
                        $display("Unknown command '%s' in the command file", op);
                    end
                    if (op == "L" || op == "R" || op == "S" || op == "W") begin
                        cmd_op.push_back(op.getc(0));
                        cmd_a.push_back(a);
                        cmd_b.push_back(b);
                    end
                end
            end
            $fclose(fd);
            n_cmds = cmd_op.size();
        end
    endtask

    task automatic wait_drain();
        while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic load_table(input logic [7:0] addr, input logic [11:0] data);
        wait_drain();                                      // No lookup in flight.
        @(posedge clk);
        load_en   <= 1'b1;
        load_addr <= addr;
        load_data <= data;
        table_model[addr] = data;
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic send_request(input logic [7:0] node, input logic [1:0] tag);
        exp_t exp;
        exp.node_id = node;
        exp.fv_addr = table_model[node];
        exp.pe_tag  = tag;
        @(negedge clk);
        while (in_full[node[0]]) begin
            @(negedge clk);
        end
        @(posedge clk);
        in_wr      <= 1'b1;
        in_node_id <= node;
        in_pe_tag  <= tag;
        if (node[0]) begin
            exp_q1.push_back(exp);
        end else begin
            exp_q0.push_back(exp);
        end
        n_requests++;
        @(posedge clk);
        in_wr <= 1'b0;
    endtask

    task automatic check_result();
        exp_t exp;
        logic hit0;
        logic hit1;
        logic bank;
        logic have;
        hit0 = exp_q0.size() > 0 && exp_q0[0].fv_addr === out_fv_addr
               && exp_q0[0].pe_tag === out_pe_tag;
        hit1 = exp_q1.size() > 0 && exp_q1[0].fv_addr === out_fv_addr
               && exp_q1[0].pe_tag === out_pe_tag;
        bank = (hit0 != hit1) ? hit1 : out_bank;           // Oldest request it answers.
        have = bank ? (exp_q1.size() > 0) : (exp_q0.size() > 0);
        assert (have) else begin
            err_count++;
            $display("Result on bank %0d arrived with no request outstanding", bank);
        end
        if (have) begin
            if (bank) begin
                exp = exp_q1.pop_front();
            end else begin
                exp = exp_q0.pop_front();
            end
            assert (out_bank === exp.node_id[0]) else begin
                err_count++;
                $display("ERR bank_steering expected %0d actual %0d",
                         exp.node_id[0], out_bank);
            end
            assert (out_fv_addr === exp.fv_addr) else begin
                err_count++;
                $display("ERR table_lookup expected %h actual %h", exp.fv_addr, out_fv_addr);
            end
            assert (out_pe_tag === exp.pe_tag) else begin
                err_count++;
                $display("ERR pe_tag expected %h actual %h", exp.pe_tag, out_pe_tag);
            end
        end
    endtask

    // Results sampled away from the driving edge.
    always @(negedge clk) begin
        if (reset === 1'b1 && out_valid === 1'b1) begin
            n_results++;
            check_result();
        end
    end

    // Random back-pressure between S stalls.
    initial begin
        void'($urandom(seed));
        out_full <= 1'b0;
        forever begin
            @(posedge clk);
            if (!reset) begin
                out_full <= 1'b0;
            end else if (stall_left > 0) begin
                out_full   <= 1'b1;
                stall_left = stall_left - 1;
            end else begin
                out_full <= ($urandom % 4 == 0);
            end
        end
    end

    initial begin
        wait (n_cmds > 0);
        #(n_cmds * 40 * 8);
        $display("Timeout after %0d commands, the results did not all arrive", n_cmds);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int total;
        reset      <= 1'b0;
        in_wr      <= 1'b0;
        in_node_id <= '0;
        in_pe_tag  <= '0;
        load_en    <= 1'b0;
        load_addr  <= '0;
        load_data  <= '0;
        read_commands();
        repeat (7) begin                                   // Eight rising edges in reset.
            @(negedge clk);
            assert (out_valid === 1'b0 && in_full === '0) else begin
                err_count++;
                $display("out_valid or in_full is not low during reset");
            end
        end
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        assert (out_valid === 1'b0 && in_full === '0) else begin
            err_count++;
            $display("out_valid or in_full is not low after reset");
        end
        foreach (cmd_op[i]) begin
            case (cmd_op[i])
                "L": load_table(cmd_a[i], cmd_b[i]);
                "R": send_request(cmd_a[i], cmd_b[i]);
                "S": begin
                    @(negedge clk);
                    stall_left = cmd_a[i];
                end
                default: repeat (cmd_a[i]) @(posedge clk);
            endcase
        end
        wait_drain();
        repeat (20) @(negedge clk);                        // Catch duplicates.
        assert (n_results == n_requests) else begin
            err_count++;
            $display("ERR result_count expected %0d actual %0d", n_requests, n_results);
        end
        total = err_count + i_dut.i_assertions.assert_fails;
        $display("Results %0d of %0d, check errors %0d, assertion failures %0d",
                 n_results, n_requests, err_count, i_dut.i_assertions.assert_fails);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/fv_lookup_input.txt
# Columns: op a b, all fields hex.
# L addr data = table load, R node_id pe_tag = request, S n = out_full stall, W n = idle.
L 00 101
L 01 1a2
L 02 2b3
L 03 3c4
L 04 4d5
L 05 5e6
L 06 6f7
L 07 708
L 10 8a9
L 11 9ba
L fe c3d
L ff d4e
R 00 0
R 01 1
R 02 2
R 03 3
R fe 1
R ff 2
W 08
S 40
R 00 0
R 02 1
R 04 2
R 06 3
R 10 0
R 00 1
R 02 2
R 04 3
R 06 0
R 10 1
R fe 2
R 00 3
R 02 0
R 04 1
R 05 2
R 07 3
W 10
L 02 f0f
L 03 e1e
R 02 1
R 03 2
R 11 3
R 06 0

//--- tb.f
src/fv_cfg_pkg.sv
src/fv_info_pkg.sv
src/fv_result_if.sv
src/req_fifo.sv
src/fv_info_sram.sv
src/fv_info_mem_cntl.sv
src/fv_info_lane.sv
src/fv_result_merge.sv
src/fv_info_lookup_top.sv
verification/fv_lookup_assertions.sv
verification/tb_fv_info_lookup.sv
